// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       := load_issue_queue_tb
RTL_TOP   := load_issue_queue
FILELIST  := load_issue_queue.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Regression passed" $(LOG) && ! grep -q "Regression failed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/load_issue_queue_tb.sv
`timescale 1ns/100ps
`include "load_issue_settings.svh"

module load_issue_queue_tb;

    localparam int MAX_ROWS = 64;
    localparam int RESET_CYCLES = 10;
    localparam int COLS = 29;
    localparam logic [1:0] LOAD_SIZE = 2'b10;

    // One trace line of inputs and expected outputs
    typedef struct packed {
        logic [1:0]       de;
        logic [1:0]       v;
        logic [1:0][5:0]  rs;
        logic [1:0][5:0]  rob;
        logic [1:0][3:0]  lq;
        logic [1:0]       we;
        logic [1:0][5:0]  wr;
        logic [1:0][5:0]  rp;
        logic             ren;
        logic [5:0]       rrob;
        logic             st;
        logic [1:0]       ie;
        logic [1:0][5:0]  orob;
        logic [1:0][3:0]  olq;
        logic [1:0][1:0]  oent;
        logic [1:0]       ox;
    } trace_row_t;

    logic clk;
    logic rst;
    logic [`LIQ_DIS_PORT-1:0] dis_en;
    load_issue_pkg::dis_load_t [`LIQ_DIS_PORT-1:0] dis_load;
    load_issue_pkg::wakeup_t [`LIQ_WB_PORT-1:0] wakeup;
    load_issue_pkg::reply_t [`LIQ_BANK_NUM-1:0] reply;
    load_issue_pkg::redirect_t redirect;
    logic dis_stall;
    logic [`LIQ_BANK_NUM-1:0] issue_en;
    load_issue_pkg::issue_load_t [`LIQ_BANK_NUM-1:0] issue_load;

    trace_row_t rows [MAX_ROWS];
    int n_rows;
    int value_errs;
    int other_errs;
    int cycles;
    int cycle_limit;

    load_issue_queue u_load_issue_queue (
        .clk          (clk),
        .rst          (rst),
        .dis_en_i     (dis_en),
        .dis_load_i   (dis_load),
        .wakeup_i     (wakeup),
        .reply_i      (reply),
        .redirect_i   (redirect),
        .dis_stall_o  (dis_stall),
        .issue_en_o   (issue_en),
        .issue_load_o (issue_load)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the trace did not finish within %0d cycles", cycle_limit);
            $display("Regression failed");
            $finish;
        end
    end

    // Destination register carried by a load with this lq index
    function automatic logic [5:0] rd_for_lq(input logic [3:0] lq);
        return 6'h20 | {2'b00, lq};
    endfunction

    function automatic logic [11:0] imm_for_lq(input logic [3:0] lq);
        return 12'h100 + {8'h00, lq};
    endfunction

    task automatic read_trace();
        int fd;
        int got;
        int t [COLS];
        string line;
        trace_row_t r;
        fd = $fopen("dv/load_issue_trace.txt", "r");
        n_rows = 0;
        if (fd == 0) begin
            $display("could not open the trace file dv/load_issue_trace.txt");
            other_errs++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line[0] == "#") continue;  // Blank or comment line
            got = $sscanf(line,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                t[0], t[1], t[2], t[3], t[4], t[5], t[6], t[7], t[8], t[9],
                t[10], t[11], t[12], t[13], t[14], t[15], t[16], t[17], t[18], t[19],
                t[20], t[21], t[22], t[23], t[24], t[25], t[26], t[27], t[28]);
            if (got != COLS) begin
                $display("trace line %0d is malformed: %s", n_rows, line);
                other_errs++;
                continue;
            end
            if (n_rows >= MAX_ROWS) begin
                $display("trace holds more than %0d lines", MAX_ROWS);
                other_errs++;
                break;
            end
            r = '0;
            for (int p = 0; p < 2; p++) begin
                r.de[p] = t[5*p][0];
                r.v[p] = t[5*p+1][0];
                r.rs[p] = t[5*p+2][5:0];
                r.rob[p] = t[5*p+3][5:0];
                r.lq[p] = t[5*p+4][3:0];
                r.we[p] = t[10+2*p][0];
                r.wr[p] = t[11+2*p][5:0];
                r.rp[p] = t[14+p][5:0];
                r.ie[p] = t[19+5*p][0];
                r.orob[p] = t[20+5*p][5:0];
                r.olq[p] = t[21+5*p][3:0];
                r.oent[p] = t[22+5*p][1:0];
                r.ox[p] = t[23+5*p][0];
            end
            r.ren = t[16][0];
            r.rrob = t[17][5:0];
            r.st = t[18][0];
            rows[n_rows] = r;
            n_rows++;
        end
        $fclose(fd);
    endtask

    task automatic drive_row(input trace_row_t r);
        for (int p = 0; p < 2; p++) begin
            dis_en[p] = r.de[p];
            dis_load[p].rs1v = r.v[p];
            dis_load[p].rs1 = r.rs[p];
            dis_load[p].rob = load_issue_pkg::rob_idx_t'(r.rob[p]);
            dis_load[p].lq = r.lq[p];
            dis_load[p].rd = rd_for_lq(r.lq[p]);  // Payload follows the lq index
            dis_load[p].imm = imm_for_lq(r.lq[p]);
            dis_load[p].size = LOAD_SIZE;
            wakeup[p].en = r.we[p];
            wakeup[p].rd = r.wr[p];
            reply[p] = load_issue_pkg::reply_t'(r.rp[p]);
        end
        redirect.en = r.ren;
        redirect.rob = load_issue_pkg::rob_idx_t'(r.rrob);
    endtask

    task automatic compare_value(input string name, input int line_no,
                                 input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("error: %s at trace line %0d expected %0h got %0h", name, line_no, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_row(input int line_no, input trace_row_t r);
        compare_value("dis_stall_o", line_no, 32'(r.st), 32'(dis_stall));
        for (int p = 0; p < 2; p++) begin
            compare_value($sformatf("issue_en_o[%0d]", p), line_no,
                          32'(r.ie[p]), 32'(issue_en[p]));
            if (r.ie[p]) begin
                compare_value($sformatf("issue_load_o[%0d].rob", p), line_no,
                              32'(r.orob[p]), 32'(issue_load[p].rob));
                compare_value($sformatf("issue_load_o[%0d].lq", p), line_no,
                              32'(r.olq[p]), 32'(issue_load[p].lq));
                compare_value($sformatf("issue_load_o[%0d].rd", p), line_no,
                              32'(rd_for_lq(r.olq[p])), 32'(issue_load[p].rd));
                compare_value($sformatf("issue_load_o[%0d].imm", p), line_no,
                              32'(imm_for_lq(r.olq[p])), 32'(issue_load[p].imm));
                compare_value($sformatf("issue_load_o[%0d].size", p), line_no,
                              32'(LOAD_SIZE), 32'(issue_load[p].size));
                compare_value($sformatf("issue_load_o[%0d].entry", p), line_no,
                              32'(r.oent[p]), 32'(issue_load[p].entry));
                compare_value($sformatf("issue_load_o[%0d].exception", p), line_no,
                              32'(r.ox[p]), 32'(issue_load[p].exception));
            end
        end
    endtask

    initial begin
        rst = 1'b1;
        dis_en = '0;
        dis_load = '0;
        wakeup = '0;
        reply = '0;
        redirect = '0;
        cycles = 0;
        value_errs = 0;
        other_errs = 0;
        cycle_limit = 1000;
        read_trace();
        cycle_limit = n_rows + RESET_CYCLES + 20;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < n_rows; i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_row(i - 1, rows[i-1]);  // Outputs after the edge that ended line i-1
            end
            drive_row(rows[i]);
        end
        @(negedge clk);
        if (n_rows > 0) begin
            check_row(n_rows - 1, rows[n_rows-1]);
        end else begin
            $display("the trace held no cycles to run");
            other_errs++;
        end
        $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: dv/load_issue_trace.txt
# Inputs: de0 v0 rs0 rob0 lq0  de1 v1 rs1 rob1 lq1  we0 wr0 we1 wr1  rp0 rp1  ren rrob
# Expected: st  ie0 rob0 lq0 ent0 exc0  ie1 rob1 lq1 ent1 exc1 (rp = replay,success,tlb,fault,entry)
# All values hex, one line per cycle, rob = {dir, idx}
0 0 00 00 0  0 0 00 00 0  0 00 0 00  00 00  0 00  0  0 00 0 0 0  0 00 0 0 0
1 1 01 01 1  1 1 02 02 2  0 00 0 00  00 00  0 00  0  0 00 0 0 0  0 00 0 0 0
0 0 00 00 0  0 0 00 00 0  0 00 0 00  00 00  0 00  0  1 01 1 0 0  1 02 2 0 0
1 1 03 03 3  0 0 00 00 0  0 00 0 00  00 00  0 00  0  0 00 0 0 0  0 00 0 0 0
1 1 04 04 4  1 0 0a 05 5  0 00 0 00  00 00  0 00  0  1 03 3 1 0  0 00 0 0 0
1 0 0b 06 6  0 0 00 00 0  1 0a 1 0b  00 00  0 00  0  0 00 0 0 0  1 04 4 1 0
0 0 00 00 0  0 0 00 00 0  0 00 0 00  00 00  0 00  0  1 05 5 2 0  1 06 6 2 0
0 0 00 00 0  0 0 00 00 0  0 00 0 00  21 10  0 00  0  0 00 0 0 0  0 00 0 0 0
1 1 07 07 7  0 0 00 00 0  0 00 0 00  0c 00  0 00  0  1 03 3 1 0  0 00 0 0 0
0 0 00 00 0  0 0 00 00 0  0 00 0 00  00 00  0 00  0  1 01 1 0 1  1 07 7 0 0
1 0 10 08 8  1 0 11 09 9  0 00 0 00  00 00  0 00  1  0 00 0 0 0  0 00 0 0 0
1 1 15 0a a  1 1 16 0b b  0 00 0 00  00 00  0 00  1  0 00 0 0 0  0 00 0 0 0
1 1 15 0a a  1 1 16 0b b  0 00 0 00  11 11  0 00  0  0 00 0 0 0  0 00 0 0 0
1 1 12 21 c  1 0 13 22 d  0 00 0 00  00 20  0 00  1  0 00 0 0 0  0 00 0 0 0
0 0 00 00 0  0 0 00 00 0  0 00 0 00  00 00  1 08  0  0 00 0 0 0  0 00 0 0 0
0 0 00 00 0  0 0 00 00 0  0 00 0 00  00 00  0 00  0  0 00 0 0 0  1 07 7 0 0
1 1 17 08 e  1 0 14 09 f  0 00 0 00  00 00  0 00  0  0 00 0 0 0  0 00 0 0 0
0 0 00 00 0  0 0 00 00 0  0 00 1 14  00 00  0 00  0  1 08 e 1 0  0 00 0 0 0
0 0 00 00 0  0 0 00 00 0  0 00 0 00  00 00  0 00  0  0 00 0 0 0  1 09 f 1 0
0 0 00 00 0  0 0 00 00 0  0 00 0 00  00 00  0 00  0  0 00 0 0 0  0 00 0 0 0
0 0 00 00 0  0 0 00 00 0  0 00 0 00  00 00  0 00  0  0 00 0 0 0  0 00 0 0 0

// File: include/load_issue_settings.svh
`ifndef LOAD_ISSUE_SETTINGS_SVH
`define LOAD_ISSUE_SETTINGS_SVH

// Queue geometry
`define LIQ_BANK_NUM   2   // Banks, one load pipeline each
`define LIQ_BANK_SIZE  4   // Entries per bank
`define LIQ_DIS_PORT   2   // Dispatch ports, one per bank
`define LIQ_WB_PORT    2   // Writeback wakeup ports

// Field widths
`define LIQ_PREG_W     6   // Physical register number
`define LIQ_ROB_W      5   // ROB index without wrap bit
`define LIQ_LQ_W       4   // Load queue index
`define LIQ_IMM_W      12  // Address offset

`endif

// File: load_issue_queue.f
+incdir+include
logic/load_issue_pkg.sv
logic/load_issue_bank.sv
logic/bank_steer.sv
logic/load_issue_queue.sv
dv/load_issue_queue_tb.sv

// File: logic/bank_steer.sv
`timescale 1ns/100ps
`include "load_issue_settings.svh"

module bank_steer (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic [`LIQ_DIS_PORT-1:0]                        dis_en_i,
    input  load_issue_pkg::dis_load_t [`LIQ_DIS_PORT-1:0]   dis_load_i,
    input  load_issue_pkg::redirect_t                       redirect_i,
    input  logic [`LIQ_BANK_NUM-1:0]                        bank_full_i,
    input  load_issue_pkg::bank_cnt_t [`LIQ_BANK_NUM-1:0]   bank_count_i,
    output logic [`LIQ_BANK_NUM-1:0]                        bank_dis_en_o,
    output load_issue_pkg::dis_load_t [`LIQ_BANK_NUM-1:0]   bank_dis_load_o,
    output logic                                            dis_stall_o
);

    localparam int BANK_W = $clog2(`LIQ_BANK_NUM);

    typedef logic [BANK_W-1:0] bank_sel_t;

    bank_sel_t [`LIQ_DIS_PORT-1:0] order_q;  // Port to bank
    bank_sel_t [`LIQ_DIS_PORT-1:0] order_d;
    logic [`LIQ_BANK_NUM-1:0] bank_hit;

    assign dis_stall_o = |bank_full_i;

    // Port 0 to the emptier bank, bank 0 on a tie
    always_comb begin
        order_d[0] = (bank_count_i[1] < bank_count_i[0]) ? bank_sel_t'(1) : bank_sel_t'(0);
        order_d[1] = ~order_d[0];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int p = 0; p < `LIQ_DIS_PORT; p++) begin
                order_q[p] <= bank_sel_t'(p);
            end
        end else begin
            order_q <= order_d;
        end
    end

    always_comb begin
        bank_dis_en_o = '0;
        bank_dis_load_o = '0;
        for (int p = 0; p < `LIQ_DIS_PORT; p++) begin
            bank_dis_en_o[order_q[p]] = dis_en_i[p] & ~dis_stall_o & ~redirect_i.en;
            bank_dis_load_o[order_q[p]] = dis_load_i[p];
        end
    end

    always_comb begin
        bank_hit = '0;
        for (int p = 0; p < `LIQ_DIS_PORT; p++) begin
            bank_hit[order_q[p]] = 1'b1;
        end
    end

    // Every bank owned by exactly one port
    a_order_perm: assert property (@(posedge clk) disable iff (rst) &bank_hit);

endmodule

// File: logic/load_issue_bank.sv
`timescale 1ns/100ps
`include "load_issue_settings.svh"

module load_issue_bank (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          dis_en_i,
    input  load_issue_pkg::dis_load_t                     dis_load_i,
    input  load_issue_pkg::wakeup_t [`LIQ_WB_PORT-1:0]    wakeup_i,
    input  load_issue_pkg::reply_t                        reply_i,
    input  load_issue_pkg::redirect_t                     redirect_i,
    output logic                                          full_o,
    output load_issue_pkg::bank_cnt_t                     count_o,
    output logic                                          issue_en_o,
    output load_issue_pkg::issue_load_t                   issue_load_o
);

    localparam int SIZE = `LIQ_BANK_SIZE;

    logic [SIZE-1:0] valid_q;
    logic [SIZE-1:0] rs1v_q;
    logic [SIZE-1:0] issued_q;
    logic [SIZE-1:0] exc_q;
    load_issue_pkg::dis_load_t payload_q [SIZE];

    logic [SIZE-1:0] valid_d;
    logic [SIZE-1:0] wake;
    logic [SIZE-1:0] younger;
    logic [SIZE-1:0] ready;
    logic dis_wake;
    logic any_ready;
    logic sel_fire;
    load_issue_pkg::bank_idx_t free_idx;
    load_issue_pkg::bank_idx_t sel_idx;

    // Index compare whose sense flips when the wrap bits differ
    function automatic logic is_younger(load_issue_pkg::rob_idx_t a,
                                        load_issue_pkg::rob_idx_t r);
        return (a.dir ^ r.dir) ^ (a.idx >= r.idx);
    endfunction

    always_comb begin
        wake = '0;
        dis_wake = 1'b0;
        for (int p = 0; p < `LIQ_WB_PORT; p++) begin
            for (int i = 0; i < SIZE; i++) begin
                if (wakeup_i[p].en && wakeup_i[p].rd == payload_q[i].rs1) begin
                    wake[i] = wake[i] | valid_q[i];
                end
            end
            if (wakeup_i[p].en && wakeup_i[p].rd == dis_load_i.rs1) begin
                dis_wake = 1'b1;                        // Wakeup racing the dispatch
            end
        end
    end

    always_comb begin
        for (int i = 0; i < SIZE; i++) begin
            ready[i] = valid_q[i] & rs1v_q[i] & ~issued_q[i];
            younger[i] = is_younger(payload_q[i].rob, redirect_i.rob);
        end
    end

    // Lowest free slot and lowest ready slot
    always_comb begin
        free_idx = '0;
        sel_idx = '0;
        for (int i = SIZE - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_idx = load_issue_pkg::bank_idx_t'(i);
            end
            if (ready[i]) begin
                sel_idx = load_issue_pkg::bank_idx_t'(i);
            end
        end
    end

    assign any_ready = |ready;
    assign sel_fire = any_ready & ~redirect_i.en;  // No pick while flushing

    always_comb begin
        valid_d = valid_q;
        if (dis_en_i) begin
            valid_d[free_idx] = 1'b1;
        end
        if (redirect_i.en) begin
            valid_d = valid_d & ~younger;
        end
        if (reply_i.success) begin
            valid_d[reply_i.entry] = 1'b0;
        end
    end

    // Occupancy after this edge for steering
    always_comb begin
        count_o = '0;
        for (int i = 0; i < SIZE; i++) begin
            count_o = count_o + load_issue_pkg::bank_cnt_t'(valid_d[i]);
        end
    end

    assign full_o = &valid_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            rs1v_q <= '0;
            issued_q <= '0;
            exc_q <= '0;
            issue_en_o <= 1'b0;
        end else begin
            valid_q <= valid_d;
            rs1v_q <= rs1v_q | wake;
            if (dis_en_i) begin
                rs1v_q[free_idx] <= dis_load_i.rs1v | dis_wake;
                issued_q[free_idx] <= 1'b0;
                exc_q[free_idx] <= 1'b0;
            end
            if (reply_i.replay || reply_i.tlb) begin
                issued_q[reply_i.entry] <= 1'b0;  // Becomes selectable again
            end
            if (reply_i.tlb && reply_i.tlb_fault) begin
                exc_q[reply_i.entry] <= 1'b1;
            end
            if (sel_fire) begin
                issued_q[sel_idx] <= 1'b1;
            end
            issue_en_o <= sel_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (dis_en_i) begin
            payload_q[free_idx] <= dis_load_i;
        end
        if (sel_fire) begin
            issue_load_o.rob <= payload_q[sel_idx].rob;
            issue_load_o.lq <= payload_q[sel_idx].lq;
            issue_load_o.rd <= payload_q[sel_idx].rd;
            issue_load_o.imm <= payload_q[sel_idx].imm;
            issue_load_o.size <= payload_q[sel_idx].size;
            issue_load_o.entry <= sel_idx;
            issue_load_o.exception <= exc_q[sel_idx];
        end
    end

    // Steering must hold back dispatch to a full bank
    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        dis_en_i |-> !full_o);

    a_success_valid: assert property (@(posedge clk) disable iff (rst)
        reply_i.success |-> valid_q[reply_i.entry]);

    a_issue_flagged: assert property (@(posedge clk) disable iff (rst)
        issue_en_o |-> issued_q[issue_load_o.entry]);

endmodule

// File: logic/load_issue_pkg.sv
`include "load_issue_settings.svh"

package load_issue_pkg;

    typedef logic [`LIQ_PREG_W-1:0] preg_t;
    typedef logic [`LIQ_LQ_W-1:0] lq_idx_t;
    typedef logic [`LIQ_IMM_W-1:0] imm_t;
    typedef logic [1:0] mem_size_t;                     // Byte, half, word
    typedef logic [$clog2(`LIQ_BANK_SIZE)-1:0] bank_idx_t;
    typedef logic [$clog2(`LIQ_BANK_SIZE):0] bank_cnt_t; // Holds 0 to full

    typedef struct packed {
        logic                   dir;                    // Wrap bit
        logic [`LIQ_ROB_W-1:0]  idx;
    } rob_idx_t;

    typedef struct packed {
        logic       rs1v;                               // Base register already ready
        preg_t      rs1;
        rob_idx_t   rob;
        lq_idx_t    lq;
        preg_t      rd;
        imm_t       imm;
        mem_size_t  size;
    } dis_load_t;

    typedef struct packed {
        rob_idx_t   rob;
        lq_idx_t    lq;
        preg_t      rd;
        imm_t       imm;
        mem_size_t  size;
        bank_idx_t  entry;                              // Returned by the pipeline on reply
        logic       exception;
    } issue_load_t;

    typedef struct packed {
        logic   en;
        preg_t  rd;
    } wakeup_t;

    typedef struct packed {
        logic       replay;
        logic       success;
        logic       tlb;
        logic       tlb_fault;
        bank_idx_t  entry;
    } reply_t;

    typedef struct packed {
        logic       en;
        rob_idx_t   rob;                                // First ROB index to squash
    } redirect_t;

endpackage

// File: logic/load_issue_queue.sv
`timescale 1ns/100ps
`include "load_issue_settings.svh"

module load_issue_queue (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic [`LIQ_DIS_PORT-1:0]                        dis_en_i,
    input  load_issue_pkg::dis_load_t [`LIQ_DIS_PORT-1:0]   dis_load_i,
    input  load_issue_pkg::wakeup_t [`LIQ_WB_PORT-1:0]      wakeup_i,
    input  load_issue_pkg::reply_t [`LIQ_BANK_NUM-1:0]      reply_i,
    input  load_issue_pkg::redirect_t                       redirect_i,
    output logic                                            dis_stall_o,
    output logic [`LIQ_BANK_NUM-1:0]                        issue_en_o,
    output load_issue_pkg::issue_load_t [`LIQ_BANK_NUM-1:0] issue_load_o
);

    logic [`LIQ_BANK_NUM-1:0] bank_dis_en;
    logic [`LIQ_BANK_NUM-1:0] bank_full;
    load_issue_pkg::dis_load_t [`LIQ_BANK_NUM-1:0] bank_dis_load;
    load_issue_pkg::bank_cnt_t [`LIQ_BANK_NUM-1:0] bank_count;

    bank_steer u_bank_steer (
        .clk             (clk),
        .rst             (rst),
        .dis_en_i        (dis_en_i),
        .dis_load_i      (dis_load_i),
        .redirect_i      (redirect_i),
        .bank_full_i     (bank_full),
        .bank_count_i    (bank_count),
        .bank_dis_en_o   (bank_dis_en),
        .bank_dis_load_o (bank_dis_load),
        .dis_stall_o     (dis_stall_o)
    );

    // Bank b feeds load pipeline b
    for (genvar b = 0; b < `LIQ_BANK_NUM; b++) begin : g_bank
        load_issue_bank u_load_issue_bank (
            .clk          (clk),
            .rst          (rst),
            .dis_en_i     (bank_dis_en[b]),
            .dis_load_i   (bank_dis_load[b]),
            .wakeup_i     (wakeup_i),
            .reply_i      (reply_i[b]),
            .redirect_i   (redirect_i),
            .full_o       (bank_full[b]),
            .count_o      (bank_count[b]),
            .issue_en_o   (issue_en_o[b]),
            .issue_load_o (issue_load_o[b])
        );
    end

endmodule
